//--- Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
TOP        = tb_rsa
FLIST      = flist.f
BUILD_DIR  = obj_dir
PASS_TEXT  = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/mont_if.sv
`timescale 1ns/1ps

// one arithmetic block and its controller
interface mont_if import rsa_arith_pkg::*; ();

	logic            start;	// one cycle pulse
	logic [OP_W-1:0] a;
	logic [OP_W-1:0] b;
	logic [OP_W-1:0] n;	// odd modulus
	logic [OP_W-1:0] result;
	logic            done;	// level, held until next start

	modport ctrl (
		output start,
		output a,
		output b,
		output n,
		input  result,
		input  done
	);

	modport unit (
		input  start,
		input  a,
		input  b,
		input  n,
		output result,
		output done
	);

endinterface

//--- design/rsa_arith_pkg.sv
package rsa_arith_pkg;

	// operand and result width
	localparam int OP_W = 256;

	// iteration counters run 0 to 256
	localparam int CNT_W = 9;

	// bit steps per montgomery product and per modulo product
	localparam int MONT_ITER = 256;

	// last exponent bit index
	localparam int EXP_LAST = 255;
	localparam int IDX_W = $clog2(OP_W);	// exponent index width

	// montgomery accumulator, two guard bits for b + n
	localparam int ACC_W = OP_W + 2;

endpackage

//--- design/rsa_core.sv
`timescale 1ns/1ps

// a^d mod n, right to left square and multiply
module rsa_core import rsa_arith_pkg::*, rsa_ctrl_pkg::*; (
	input  logic            i_clk,
	input  logic            i_rst,
	input  logic            i_start,
	input  logic [OP_W-1:0] i_a,	// cipher text
	input  logic [OP_W-1:0] i_d,	// private exponent
	input  logic [OP_W-1:0] i_n,	// odd modulus
	output logic [OP_W-1:0] o_a_pow_d,	// plain text
	output logic            o_finished
);

	rsa_state_e       state_r;
	logic [IDX_W-1:0] idx_r;	// exponent bit in use
	logic             prep_start_r;
	logic             mont_start_r;	// sq and mul always start together
	logic             fin_r;
	logic [OP_W-1:0]  out_r;
	logic [OP_W-1:0]  a_r;
	logic [OP_W-1:0]  d_r;
	logic [OP_W-1:0]  n_r;
	logic [OP_W-1:0]  t_r;	// a^(2^i) in montgomery form
	logic [OP_W-1:0]  m_r;	// running product, plain form
	logic [OP_W-1:0]  m_next;
	logic             accept;
	logic             prep_ready;
	logic             mont_ready;
	logic             last_bit;

	mont_if prep_if ();
	mont_if sq_if ();
	mont_if mul_if ();

	// prep turns a into a * 2^256 mod n
	assign prep_if.start = prep_start_r;
	assign prep_if.a     = '0;
	assign prep_if.b     = a_r;
	assign prep_if.n     = n_r;

	assign sq_if.start = mont_start_r;
	assign sq_if.a     = t_r;
	assign sq_if.b     = t_r;
	assign sq_if.n     = n_r;

	assign mul_if.start = mont_start_r;
	assign mul_if.a     = m_r;
	assign mul_if.b     = t_r;
	assign mul_if.n     = n_r;

	rsa_modprod u_prep (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.u     (prep_if.unit)
	);

	rsa_mont u_sq (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.u     (sq_if.unit)
	);

	rsa_mont u_mul (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.u     (mul_if.unit)
	);

	assign accept = (state_r == IDLE) && i_start;

	// done of the last round is still up while the start pulse is out
	assign prep_ready = !prep_start_r && prep_if.done;
	assign mont_ready = !mont_start_r && sq_if.done && mul_if.done;

	assign last_bit = (idx_r == IDX_W'(EXP_LAST));
	assign m_next   = d_r[idx_r] ? mul_if.result : m_r;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r      <= RSA_RESET_STATE;
			idx_r        <= '0;
			prep_start_r <= 1'b0;
			mont_start_r <= 1'b0;
			fin_r        <= 1'b0;
			out_r        <= '0;
		end else begin
			prep_start_r <= 1'b0;
			mont_start_r <= 1'b0;
			case (state_r)
				IDLE: begin
					if (accept) begin
						state_r      <= PREP;
						prep_start_r <= 1'b1;
						fin_r        <= 1'b0;
					end
				end
				PREP: begin
					if (prep_ready) begin
						state_r      <= MONT;
						mont_start_r <= 1'b1;
						idx_r        <= '0;
					end
				end
				MONT: begin
					if (mont_ready) state_r <= CALC;
				end
				CALC: begin
					if (last_bit) begin	// m_next is the answer
						state_r <= IDLE;
						out_r   <= m_next;
						fin_r   <= 1'b1;
					end else begin
						state_r      <= MONT;
						idx_r        <= idx_r + 1'b1;
						mont_start_r <= 1'b1;
					end
				end
				default: state_r <= IDLE;
			endcase
		end
	end

	// operands and working values
	always_ff @(posedge i_clk) begin
		if (accept) begin
			a_r <= i_a;
			d_r <= i_d;
			n_r <= i_n;
		end
		if (state_r == PREP && prep_ready) begin
			t_r <= prep_if.result;
			m_r <= OP_W'(1);	// R factor cancels in the first multiply
		end
		if (state_r == CALC) begin
			t_r <= sq_if.result;
			m_r <= m_next;
		end
	end

	assign o_a_pow_d  = out_r;
	assign o_finished = fin_r;

endmodule

//--- design/rsa_ctrl_pkg.sv
package rsa_ctrl_pkg;

	// exponent sequencer states
	typedef enum logic [1:0] {
		IDLE = 2'd0,	// wait for start
		PREP = 2'd1,	// message into montgomery form
		MONT = 2'd2,	// square and multiply in flight
		CALC = 2'd3	// pick new t and m, step the index
	} rsa_state_e;

	// the controller sits in IDLE between runs
	localparam rsa_state_e RSA_RESET_STATE = IDLE;

endpackage

//--- design/rsa_modprod.sv
`timescale 1ns/1ps

// b * 2^256 mod n by repeated doubling
module rsa_modprod import rsa_arith_pkg::*; (
	input  logic i_clk,
	input  logic i_rst,
	mont_if.unit u
);

	logic [CNT_W-1:0] cnt_r;
	logic             busy_r;
	logic             done_r;
	logic             last_step;
	logic [OP_W-1:0]  t_r;	// running remainder, always below n
	logic [OP_W-1:0]  b_mod;
	logic [OP_W:0]    n_ext;
	logic [OP_W:0]    t_dbl;
	logic [OP_W:0]    t_red;

	assign n_ext = {1'b0, u.n};

	// b is below n in normal use, one subtraction covers b < 2n
	assign b_mod = (u.b >= u.n) ? u.b - u.n : u.b;

	always_comb begin
		t_dbl = {t_r, 1'b0};
		t_red = (t_dbl >= n_ext) ? t_dbl - n_ext : t_dbl;	// 2t < 2n
	end

	assign last_step = busy_r && (cnt_r == CNT_W'(MONT_ITER - 1));

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy_r <= 1'b0;
			done_r <= 1'b0;
			cnt_r  <= '0;
		end else if (u.start) begin	// also restarts a busy block
			busy_r <= 1'b1;
			done_r <= 1'b0;
			cnt_r  <= '0;
		end else if (busy_r) begin
			cnt_r <= cnt_r + 1'b1;
			if (last_step) begin
				busy_r <= 1'b0;
				done_r <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (u.start) begin
			t_r <= b_mod;
		end else if (busy_r) begin
			t_r <= t_red[OP_W-1:0];
		end
	end

	assign u.result = t_r;	// stays put once busy drops
	assign u.done   = done_r;

endmodule

//--- design/rsa_mont.sv
`timescale 1ns/1ps

// radix 2 montgomery product a * b * 2^-256 mod n
module rsa_mont import rsa_arith_pkg::*; (
	input  logic i_clk,
	input  logic i_rst,
	mont_if.unit u
);

	logic [CNT_W-1:0] cnt_r;
	logic             busy_r;
	logic             done_r;
	logic             last_step;
	logic [OP_W-1:0]  a_sh_r;	// multiplier bits, lsb first
	logic [ACC_W-1:0] acc_r;	// below 2n between steps
	logic [ACC_W-1:0] b_ext;
	logic [ACC_W-1:0] n_ext;
	logic [ACC_W-1:0] sum_b;
	logic [ACC_W-1:0] sum_n;
	logic [ACC_W-1:0] half;
	logic [ACC_W-1:0] acc_red;

	assign b_ext = ACC_W'(u.b);
	assign n_ext = ACC_W'(u.n);

	always_comb begin
		sum_b = acc_r + (a_sh_r[0] ? b_ext : '0);
		// odd n makes the sum even
		sum_n = sum_b[0] ? sum_b + n_ext : sum_b;
		half  = sum_n >> 1;
		// final correction, only taken on the last step
		acc_red = (half >= n_ext) ? half - n_ext : half;
	end

	assign last_step = busy_r && (cnt_r == CNT_W'(MONT_ITER - 1));

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy_r <= 1'b0;
			done_r <= 1'b0;
			cnt_r  <= '0;
		end else if (u.start) begin
			busy_r <= 1'b1;
			done_r <= 1'b0;
			cnt_r  <= '0;
		end else if (busy_r) begin
			cnt_r <= cnt_r + 1'b1;
			if (last_step) begin
				busy_r <= 1'b0;
				done_r <= 1'b1;	// result below n from here
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (u.start) begin
			acc_r  <= '0;
			a_sh_r <= u.a;
		end else if (busy_r) begin
			acc_r  <= last_step ? acc_red : half;
			a_sh_r <= a_sh_r >> 1;
		end
	end

	assign u.result = acc_r[OP_W-1:0];
	assign u.done   = done_r;

endmodule

//--- flist.f
design/rsa_arith_pkg.sv
design/rsa_ctrl_pkg.sv
design/mont_if.sv
design/rsa_modprod.sv
design/rsa_mont.sv
design/rsa_core.sv
test/rsa_props.sv
test/tb_rsa.sv

//--- test/rsa_props.sv
`timescale 1ns/1ps

// sequencer checks, bound into rsa_core
module rsa_props import rsa_arith_pkg::*, rsa_ctrl_pkg::*; (
	input logic       i_clk,
	input logic       i_rst,
	input logic       i_start,
	input rsa_state_e state,
	input logic       prep_start,
	input logic       mont_start,
	input logic       o_finished
);

	// accepted start clears the finished level
	finish_drop: assert property (@(posedge i_clk) disable iff (i_rst)
		(state == IDLE && i_start) |=> !o_finished)
		else $error("o_finished still high after an accepted start");

	prep_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
		prep_start |=> !prep_start)
		else $error("prep start pulse longer than one cycle");

	mont_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
		mont_start |=> !mont_start)
		else $error("multiplier start pulse longer than one cycle");

	idle_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		(state == IDLE && !i_start) |=> state == IDLE)
		else $error("controller left IDLE without a start");

endmodule

bind rsa_core rsa_props props_i (
	.i_clk      (i_clk),
	.i_rst      (i_rst),
	.i_start    (i_start),
	.state      (state_r),
	.prep_start (prep_start_r),
	.mont_start (mont_start_r),
	.o_finished (o_finished)
);

//--- test/tb_rsa.sv
`timescale 1ns/1ps

module tb_rsa import rsa_arith_pkg::*; ();

	localparam int NUM_RUNS    = 11;	// run lengths including the idle watch and the abort
	localparam int CYCLE_LIMIT = NUM_RUNS * 70000 + 5000;

	logic            i_clk;
	logic            i_rst;
	logic            i_start;
	logic [OP_W-1:0] i_a;
	logic [OP_W-1:0] i_d;
	logic [OP_W-1:0] i_n;
	logic [OP_W-1:0] o_a_pow_d;
	logic            o_finished;

	logic [OP_W-1:0] exp_q[$];	// expected results in start order
	logic [31:0]     lfsr_r = 32'hfe777694;
	int              done_cnt = 0;
	int              cycles = 0;
	int              errors = 0;
	int              checks = 0;
	int              tests = 0;
	int              failed_tests = 0;
	int              err_mark;
	string           cur_name;

	rsa_core dut_i (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_start    (i_start),
		.i_a        (i_a),
		.i_d        (i_d),
		.i_n        (i_n),
		.o_a_pow_d  (o_a_pow_d),
		.o_finished (o_finished)
	);

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic rand_word(output logic [OP_W-1:0] w);
		int i;
		for (i = 0; i < OP_W; i++) begin
			lfsr_r = lfsr_next(lfsr_r);
			w[i] = lfsr_r[0];
		end
	endtask

	task automatic pick_operands(output logic [OP_W-1:0] a, d, n);
		rand_word(n);
		n[0] = 1'b1;	// modulus must be odd
		rand_word(a);
		a = a % n;
		rand_word(d);
	endtask

	function automatic logic [OP_W-1:0] mul_mod(input logic [OP_W-1:0] x, y, n);
		logic [2*OP_W-1:0] p;
		p = {{OP_W{1'b0}}, x} * {{OP_W{1'b0}}, y};
		return OP_W'(p % {{OP_W{1'b0}}, n});
	endfunction

	// plain square and multiply from the lsb up
	function automatic logic [OP_W-1:0] mod_pow(input logic [OP_W-1:0] a, d, n);
		logic [OP_W-1:0] r;
		logic [OP_W-1:0] base;
		int              i;
		r    = OP_W'(1) % n;
		base = a % n;
		for (i = 0; i < OP_W; i++) begin
			if (d[i]) r = mul_mod(r, base, n);
			base = mul_mod(base, base, n);
		end
		return r;
	endfunction

	task automatic check_value(input string what, input logic [OP_W-1:0] got, expv);
		checks++;
		assert (got == expv) else begin
			errors++;
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, expv);
		end
	endtask

	task automatic must_hold(input logic cond, input string msg);
		checks++;
		assert (cond) else begin
			errors++;
			$display("error at %0t ns: %s", $time, msg);
		end
	endtask

	task automatic begin_test(input string name);
		cur_name = name;
		err_mark = errors;
		tests++;
	endtask

	task automatic end_test();
		if (errors == err_mark) begin
			$display("test %0d %s: pass", tests, cur_name);
		end else begin
			failed_tests++;
			$display("test %0d %s: failed with %0d errors", tests, cur_name, errors - err_mark);
		end
	endtask

	task automatic start_run(input logic [OP_W-1:0] a, d, n);
		@(posedge i_clk);
		#1;
		i_a     = a;
		i_d     = d;
		i_n     = n;
		i_start = 1'b1;
		@(posedge i_clk);
		#1;
		i_start = 1'b0;
	endtask

	task automatic wait_finish(input int mark);
		while (done_cnt == mark) @(posedge i_clk);
	endtask

	task automatic run_and_check(input logic [OP_W-1:0] a, d, n, expv);
		int mark;
		mark = done_cnt;
		exp_q.push_back(expv);
		start_run(a, d, n);
		wait_finish(mark);
	endtask

	// compare on each rising o_finished at the next falling edge
	initial begin
		logic [OP_W-1:0] expv;
		forever begin
			@(posedge o_finished);
			@(negedge i_clk);
			if (exp_q.size() == 0) begin
				must_hold(1'b0, "o_finished rose with no run pending");
			end else begin
				expv = exp_q.pop_front();
				check_value("o_a_pow_d", o_a_pow_d, expv);
			end
			done_cnt++;
		end
	end

	always @(posedge i_clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the DUT never finished", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		logic [OP_W-1:0] ra, rd, rn, xa, xd, xn;
		int              k;
		int              mark;
		int              start_cyc;
		i_rst   = 1'b1;
		i_start = 1'b0;
		i_a     = '0;
		i_d     = '0;
		i_n     = '0;
		repeat (4) @(posedge i_clk);
		#1;
		i_rst = 1'b0;

		begin_test("reset values");
		check_value("o_finished after reset", OP_W'(o_finished), '0);
		check_value("o_a_pow_d after reset", o_a_pow_d, '0);
		end_test();

		begin_test("known values");
		check_value("reference 4^13 mod 497", mod_pow(4, 13, 497), OP_W'(445));
		run_and_check(OP_W'(4), OP_W'(13), OP_W'(497), OP_W'(445));
		end_test();

		begin_test("edge exponents");
		pick_operands(ra, rd, rn);
		run_and_check(ra, '0, rn, OP_W'(1));
		run_and_check(ra, OP_W'(1), rn, ra);
		run_and_check(ra, '1, rn, mod_pow(ra, '1, rn));
		end_test();

		begin_test("random back to back");
		for (k = 0; k < 3; k++) begin
			pick_operands(ra, rd, rn);
			run_and_check(ra, rd, rn, mod_pow(ra, rd, rn));
		end
		end_test();

		begin_test("start while busy");
		pick_operands(ra, rd, rn);
		pick_operands(xa, xd, xn);
		mark = done_cnt;
		exp_q.push_back(mod_pow(ra, rd, rn));
		start_cyc = cycles;
		start_run(ra, rd, rn);
		repeat (1000) @(posedge i_clk);
		start_run(xa, xd, xn);	// must be ignored
		wait_finish(mark);
		// a queued second run would need one more run length
		repeat (cycles - start_cyc + 1000) @(posedge i_clk);
		must_hold(done_cnt == mark + 1, "o_finished rose more than once for one run");
		end_test();

		begin_test("mid-run reset");
		pick_operands(ra, rd, rn);
		mark = done_cnt;
		exp_q.push_back(mod_pow(ra, rd, rn));
		start_run(ra, rd, rn);
		repeat (5000) @(posedge i_clk);
		#1;
		i_rst = 1'b1;
		exp_q.delete();	// aborted run has no result
		repeat (4) @(posedge i_clk);
		#1;
		check_value("o_finished during reset", OP_W'(o_finished), '0);
		check_value("o_a_pow_d during reset", o_a_pow_d, '0);
		i_rst = 1'b0;
		must_hold(done_cnt == mark, "o_finished rose for an aborted run");
		run_and_check(ra, rd, rn, mod_pow(ra, rd, rn));
		end_test();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
